//--- logic/core_pkg.sv
package core_pkg;

    // datapath and address width of the core
    localparam int unsigned XLEN = 64;

    // base instructions only, no compressed
    localparam int unsigned INST_W = 32;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // rom geometry, one 64-bit word per entry
    localparam int unsigned ROM_WORDS = 32;
    localparam int unsigned ROM_AW    = 5;      // word index width, log2 of ROM_WORDS

    // line held by the read master
    localparam int unsigned LINE_BEATS = 4;     // 64-bit beats per line
    localparam int unsigned LINE_OFS_W = 5;     // byte offset bits inside a 32-byte line

endpackage

//--- logic/axi_pkg.sv
package axi_pkg;

    // burst type codes, only incr is issued here
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // beat size code, 8 bytes per beat
    localparam logic [2:0] AXI_SIZE_8B = 3'b011;

    // one line is four beats, len field holds beats minus one
    localparam logic [7:0] AXI_LEN_LINE = 8'd3;

    // prot bits: [0] privileged, [1] non-secure, [2] instruction
    // fixed unprivileged secure data access
    localparam logic [2:0] AXI_PROT_DATA = 3'b000;

    // read response, slave never reports errors
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // read master FSM
    // gray-ish encoding, only one bit flips per normal step
    typedef enum logic [1:0] {
        RD_IDLE    = 2'b00,   // nothing held, nothing pending
        RD_AR_WAIT = 2'b01,   // address phase, ar_valid up
        RD_R_WAIT  = 2'b11,   // collecting beats
        RD_LINE_OK = 2'b10    // line held, hits answered from buffer
    } rd_state_e;

endpackage

//--- logic/axi_rd_master.sv
`timescale 1ns/1ps

module axi_rd_master (
    input  logic                      clock,
    input  logic                      reset,

    // request side from fetch unit
    input  logic                      rw_valid_i,
    input  logic [core_pkg::XLEN-1:0] rw_addr_i,
    output logic                      rw_ready_o,
    output logic [core_pkg::XLEN-1:0] rw_data_o,
    output logic                      fetching_o,

    // axi read address channel
    input  logic                      axi_ar_ready_i,
    output logic                      axi_ar_valid_o,
    output logic [core_pkg::XLEN-1:0] axi_ar_addr_o,
    output logic [7:0]                axi_ar_len_o,
    output logic [2:0]                axi_ar_size_o,
    output logic [1:0]                axi_ar_burst_o,
    output logic [2:0]                axi_ar_prot_o,

    // axi read data channel
    output logic                      axi_r_ready_o,
    input  logic                      axi_r_valid_i,
    input  logic [core_pkg::XLEN-1:0] axi_r_data_i,
    input  logic [1:0]                axi_r_resp_i,
    input  logic                      axi_r_last_i
);

    import core_pkg::*;
    import axi_pkg::*;

    rd_state_e state_q, state_d;

    logic [XLEN-1:0]               line_addr_q;   // line-aligned address of held line
    logic [XLEN-1:0]               line_buf [LINE_BEATS];
    logic [$clog2(LINE_BEATS)-1:0] beat_q;        // next buffer slot to fill

    logic line_hit;
    logic enter_ar;
    logic beat_fire;

    // tag compare on the bits above the line offset
    assign line_hit = (rw_addr_i[XLEN-1:LINE_OFS_W] == line_addr_q[XLEN-1:LINE_OFS_W]);

    assign beat_fire = axi_r_valid_i && axi_r_ready_o;

    // next state and request-side outputs
    always_comb begin
        state_d    = state_q;
        rw_ready_o = 1'b0;
        fetching_o = 1'b0;
        case (state_q)
            RD_IDLE: begin
                if (rw_valid_i) begin
                    state_d = RD_AR_WAIT;     // first miss after reset
                end
            end
            RD_AR_WAIT: begin
                fetching_o = 1'b1;
                if (axi_ar_ready_i) begin
                    state_d = RD_R_WAIT;
                end
            end
            RD_R_WAIT: begin
                fetching_o = 1'b1;
                // burst always runs to the end and the address is rechecked afterwards
                if (beat_fire && axi_r_last_i) begin
                    state_d = RD_LINE_OK;
                end
            end
            RD_LINE_OK: begin
                if (rw_valid_i) begin
                    if (line_hit) begin
                        rw_ready_o = 1'b1;    // same-cycle answer
                    end else begin
                        fetching_o = 1'b1;    // miss starts a refill
                        state_d    = RD_AR_WAIT;
                    end
                end
                // line kept here while nothing is requested
            end
            default: begin
                state_d = RD_IDLE;
            end
        endcase
    end

    assign enter_ar = (state_d == RD_AR_WAIT) && (state_q != RD_AR_WAIT);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= RD_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (axi_ar_valid_o && axi_ar_ready_i) begin
                beat_q <= '0;                 // new burst fills from slot 0
            end else if (beat_fire) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // line address taken once on entry to the address phase
    always_ff @(posedge clock) begin
        if (enter_ar) begin
            line_addr_q <= {rw_addr_i[XLEN-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
        end
    end

    // line buffer with one slot per beat
    always_ff @(posedge clock) begin
        if (beat_fire) begin
            line_buf[beat_q] <= axi_r_data_i;
        end
    end

    // word select inside the line is qualified by rw_ready_o
    assign rw_data_o = line_buf[rw_addr_i[LINE_OFS_W-1:3]];

    // ar channel with a fixed burst shape
    assign axi_ar_valid_o = (state_q == RD_AR_WAIT);
    assign axi_ar_addr_o  = line_addr_q;
    assign axi_ar_len_o   = AXI_LEN_LINE;
    assign axi_ar_size_o  = AXI_SIZE_8B;
    assign axi_ar_burst_o = AXI_BURST_INCR;
    assign axi_ar_prot_o  = AXI_PROT_DATA;

    assign axi_r_ready_o  = (state_q == RD_R_WAIT);

    // slave ends the burst exactly on the last buffer slot
    a_last_slot: assert property (@(posedge clock) disable iff (!reset)
        beat_fire && axi_r_last_i |-> beat_q == LINE_BEATS - 1);

    // fetch side only ever asks for whole 64-bit words
    a_rw_align: assert property (@(posedge clock) disable iff (!reset)
        rw_valid_i |-> rw_addr_i[2:0] == 3'b000);

    // slave never reports an error on a beat we take
    a_resp_ok: assert property (@(posedge clock) disable iff (!reset)
        beat_fire |-> axi_r_resp_i == AXI_RESP_OKAY);

endmodule

//--- logic/axi_rom_slave.sv
`timescale 1ns/1ps

module axi_rom_slave (
    input  logic                      clock,
    input  logic                      reset,

    // read address channel from the master
    input  logic                      axi_ar_valid_i,
    input  logic [core_pkg::XLEN-1:0] axi_ar_addr_i,
    input  logic [7:0]                axi_ar_len_i,
    output logic                      axi_ar_ready_o,

    // read data channel to the master
    input  logic                      axi_r_ready_i,
    output logic                      axi_r_valid_o,
    output logic [core_pkg::XLEN-1:0] axi_r_data_o,
    output logic [1:0]                axi_r_resp_o,
    output logic                      axi_r_last_o
);

    import core_pkg::*;
    import axi_pkg::*;

    logic [XLEN-1:0] rom [ROM_WORDS];

    logic              ar_ready_q;  // registered ready one cycle after valid
    logic              busy_q;      // set while the beats of a burst go out
    logic [7:0]        len_q;       // beats minus one of current burst
    logic [7:0]        cnt_q;       // beats already sent
    logic [ROM_AW-1:0] idx_q;       // current word index wrapping mod ROM_WORDS

    logic [XLEN-1:0] ar_offset;
    logic            ar_fire;
    logic            r_fire;

    initial begin
        $readmemh("rom.hex", rom);
    end

    // rom base sits at the reset pc
    assign ar_offset = axi_ar_addr_i - RESET_PC;

    assign ar_fire = axi_ar_valid_i && axi_ar_ready_o;
    assign r_fire  = axi_r_valid_o && axi_r_ready_i;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready_q <= 1'b0;
            busy_q     <= 1'b0;
            cnt_q      <= '0;
        end else begin
            // one burst at a time and ready pulses for a single cycle
            ar_ready_q <= axi_ar_valid_i && !ar_ready_q && !busy_q;
            if (ar_fire) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (r_fire) begin
                cnt_q <= cnt_q + 1'b1;
                if (axi_r_last_o) begin
                    busy_q <= 1'b0;           // burst done
                end
            end
        end
    end

    // start word and length of the current burst
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            idx_q <= ar_offset[ROM_AW+2:3];   // byte address to word index
            len_q <= axi_ar_len_i;
        end else if (r_fire) begin
            idx_q <= idx_q + 1'b1;            // natural wrap at ROM_WORDS
        end
    end

    assign axi_ar_ready_o = ar_ready_q;

    // beats go out on consecutive cycles unless r_ready stalls them
    assign axi_r_valid_o = busy_q;
    assign axi_r_data_o  = rom[idx_q];
    assign axi_r_resp_o  = AXI_RESP_OKAY;
    assign axi_r_last_o  = busy_q && (cnt_q == len_q);

    // data only ever follows an accepted address
    a_r_after_ar: assert property (@(posedge clock) disable iff (!reset)
        $rose(axi_r_valid_o) |-> $past(axi_ar_valid_i && axi_ar_ready_o));

    // master keeps the address phase steady until it is taken
    a_ar_stable: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_i && !axi_ar_ready_o |=>
            axi_ar_valid_i && $stable(axi_ar_addr_i) && $stable(axi_ar_len_i));

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                        clock,
    input  logic                        reset,

    input  logic                        redirect_i,
    input  logic [core_pkg::XLEN-1:0]   redirect_pc_i,

    // downstream instruction handshake
    input  logic                        instr_ready_i,
    output logic                        instr_valid_o,
    output logic [core_pkg::INST_W-1:0] instr_o,
    output logic [core_pkg::XLEN-1:0]   instr_pc_o,

    // word requests to the read master
    output logic                        rw_valid_o,
    output logic [core_pkg::XLEN-1:0]   rw_addr_o,
    input  logic                        rw_ready_i,
    input  logic [core_pkg::XLEN-1:0]   rw_data_i
);

    import core_pkg::*;

    logic [XLEN-1:0]   pc_q;           // pc of next instruction to present
    logic              run_q;          // low for the reset cycle only
    logic              word_ok_q;      // word buffer holds valid data
    logic [XLEN-1:0]   word_q;
    logic [XLEN-4:0]   word_addr_q;    // word address of word_q, bits above 2:0
    logic              instr_valid_q;
    logic [INST_W-1:0] instr_q;
    logic [XLEN-1:0]   instr_pc_q;

    logic            word_hit;
    logic            slot_free;
    logic            rw_fire;
    logic            load;
    logic [XLEN-1:0] src_word;

    assign word_hit  = word_ok_q && (pc_q[XLEN-1:3] == word_addr_q);
    assign slot_free = !instr_valid_q || instr_ready_i;

    // request only with an empty output slot and nothing buffered
    assign rw_valid_o = run_q && !instr_valid_q && !word_hit;
    assign rw_addr_o  = {pc_q[XLEN-1:3], 3'b000};
    assign rw_fire    = rw_valid_o && rw_ready_i;

    assign src_word = word_hit ? word_q : rw_data_i;
    assign load     = !redirect_i && slot_free && (word_hit || rw_fire);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc_q          <= RESET_PC;
            run_q         <= 1'b0;
            word_ok_q     <= 1'b0;
            instr_valid_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                pc_q          <= redirect_pc_i;
                word_ok_q     <= 1'b0;        // force a fresh request
                instr_valid_q <= 1'b0;        // drop anything not yet taken
            end else begin
                if (rw_fire) begin
                    word_ok_q <= 1'b1;
                end
                if (load) begin
                    pc_q          <= pc_q + 64'd4;
                    instr_valid_q <= 1'b1;
                end else if (instr_ready_i) begin
                    instr_valid_q <= 1'b0;    // taken, nothing new ready
                end
            end
        end
    end

    // payload, written under the control above
    always_ff @(posedge clock) begin
        if (rw_fire) begin
            word_q      <= rw_data_i;
            word_addr_q <= pc_q[XLEN-1:3];
        end
        if (load) begin
            instr_q    <= pc_q[2] ? src_word[63:32] : src_word[31:0];  // little-endian halves
            instr_pc_q <= pc_q;
        end
    end

    assign instr_valid_o = instr_valid_q;
    assign instr_o       = instr_q;
    assign instr_pc_o    = instr_pc_q;

    // held instruction stays put until taken or flushed
    a_instr_hold: assert property (@(posedge clock) disable iff (!reset)
        instr_valid_o && !instr_ready_i && !redirect_i |=>
            instr_valid_o && $stable(instr_o) && $stable(instr_pc_o));

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        redirect_i,
    input  logic [core_pkg::XLEN-1:0]   redirect_pc_i,
    input  logic                        instr_ready_i,
    output logic                        instr_valid_o,
    output logic [core_pkg::INST_W-1:0] instr_o,
    output logic [core_pkg::XLEN-1:0]   instr_pc_o,
    output logic                        fetching_o
);

    import core_pkg::*;

    // fetch unit to read master
    logic            rw_valid;
    logic [XLEN-1:0] rw_addr;
    logic            rw_ready;
    logic [XLEN-1:0] rw_data;

    // read master to rom, ar and r only
    logic            ar_valid;
    logic            ar_ready;
    logic [XLEN-1:0] ar_addr;
    logic [7:0]      ar_len;
    logic            r_valid;
    logic            r_ready;
    logic [XLEN-1:0] r_data;
    logic [1:0]      r_resp;
    logic            r_last;

    fetch_unit u_fetch (
        .clock         (clock),
        .reset         (reset),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .instr_ready_i (instr_ready_i),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .rw_valid_o    (rw_valid),
        .rw_addr_o     (rw_addr),
        .rw_ready_i    (rw_ready),
        .rw_data_i     (rw_data)
    );

    // size, burst and prot are fixed, rom serves only 8-byte incr
    axi_rd_master u_master (
        .clock          (clock),
        .reset          (reset),
        .rw_valid_i     (rw_valid),
        .rw_addr_i      (rw_addr),
        .rw_ready_o     (rw_ready),
        .rw_data_o      (rw_data),
        .fetching_o     (fetching_o),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_addr_o  (ar_addr),
        .axi_ar_len_o   (ar_len),
        .axi_ar_size_o  (),
        .axi_ar_burst_o (),
        .axi_ar_prot_o  (),
        .axi_r_ready_o  (r_ready),
        .axi_r_valid_i  (r_valid),
        .axi_r_data_i   (r_data),
        .axi_r_resp_i   (r_resp),
        .axi_r_last_i   (r_last)
    );

    axi_rom_slave u_rom (
        .clock          (clock),
        .reset          (reset),
        .axi_ar_valid_i (ar_valid),
        .axi_ar_addr_i  (ar_addr),
        .axi_ar_len_i   (ar_len),
        .axi_ar_ready_o (ar_ready),
        .axi_r_ready_i  (r_ready),
        .axi_r_valid_o  (r_valid),
        .axi_r_data_o   (r_data),
        .axi_r_resp_o   (r_resp),
        .axi_r_last_o   (r_last)
    );

endmodule

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    import core_pkg::*;
    import axi_pkg::*;

    localparam int WAIT_LIMIT = 300;    // cycles allowed in any one wait loop
    localparam int ROWS       = 8;

    // redirect target, instructions to collect, random stalls on
    typedef struct packed {
        logic [XLEN-1:0] target;
        logic [15:0]     count;
        logic            stall;
    } row_t;

    logic              clock;
    logic              reset;
    logic              redirect_i;
    logic [XLEN-1:0]   redirect_pc_i;
    logic              instr_ready_i;
    logic              instr_valid_o;
    logic [INST_W-1:0] instr_o;
    logic [XLEN-1:0]   instr_pc_o;
    logic              fetching_o;

    logic [XLEN-1:0] model_rom [ROM_WORDS];
    row_t            rows [ROWS];
    logic [31:0]     lfsr;
    logic [XLEN-1:0] held_pc;           // instruction presented when redirect hits
    int              checks;
    int              errors;
    int              tests;
    int              failed_tests;
    int              errs_before;
    bit              aborted;

    fetch_top UUT (
        .clock         (clock),
        .reset         (reset),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .instr_ready_i (instr_ready_i),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .fetching_o    (fetching_o)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;      // 8 ns period
    end

    // fibonacci lfsr, taps 32 22 2 1, new bit enters at [0]
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // rom word by offset from reset pc, 32 words then wrap
    function automatic logic [INST_W-1:0] expected_instr(input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] ofs;
        logic [XLEN-1:0] word;
        ofs  = ((pc - RESET_PC) >> 3) % 64'(ROM_WORDS);
        word = model_rom[ofs[ROM_AW-1:0]];
        return pc[2] ? word[63:32] : word[31:0];
    endfunction

    function automatic logic [XLEN-1:0] line_of(input logic [XLEN-1:0] pc);
        return pc >> LINE_OFS_W;        // 32-byte line number
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors != errs_before || aborted) begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
        end else begin
            $display("test %0d %s: ok", tests, name);
        end
    endtask

    // take n instructions from first_pc, checking order, value and line fetches
    task automatic collect_instrs(input string name, input logic [XLEN-1:0] first_pc,
                                  input int n, input bit stall, input bit miss_first);
        logic [XLEN-1:0] exp_pc;
        int              got;
        int              idle;
        bit              seen_fetch;
        bit              want_fetch;
        exp_pc     = first_pc;
        got        = 0;
        idle       = 0;
        seen_fetch = 1'b0;
        while (got < n && !aborted) begin
            @(posedge clock);
            if (stall) begin
                lfsr = lfsr_step(lfsr);
                instr_ready_i <= !lfsr[0];      // stepped bit 1 stalls
            end else begin
                instr_ready_i <= 1'b1;
            end
            @(negedge clock);
            if (fetching_o) begin
                seen_fetch = 1'b1;
            end
            if (instr_valid_o && instr_ready_i) begin     // taken at next edge
                check_value("instr_pc_o", instr_pc_o, exp_pc);
                check_value("instr_o", 64'(instr_o), 64'(expected_instr(exp_pc)));
                // bus fetch only when the line changes
                want_fetch = (got == 0) ? miss_first
                                        : (line_of(exp_pc) != line_of(exp_pc - 64'd4));
                check_value("fetching_o", 64'(seen_fetch), 64'(want_fetch));
                seen_fetch = 1'b0;
                exp_pc     = exp_pc + 64'd4;
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    $display("timeout: instruction %0d of %s never arrived", got, name);
                    aborted = 1'b1;
                end
            end
        end
    endtask

    // stop taking and wait for a presented instruction, so no request is open
    task automatic hold_instr();
        int idle;
        idle = 0;
        @(posedge clock);
        instr_ready_i <= 1'b0;
        @(negedge clock);
        while (!instr_valid_o && !aborted) begin
            @(negedge clock);
            idle++;
            if (idle > WAIT_LIMIT) begin
                $display("timeout: no instruction presented before redirect");
                aborted = 1'b1;
            end
        end
        held_pc = instr_pc_o;
    endtask

    task automatic apply_redirect(input logic [XLEN-1:0] target);
        @(posedge clock);
        redirect_i    <= 1'b1;
        redirect_pc_i <= target;
        @(posedge clock);
        redirect_i    <= 1'b0;
    endtask

    // reset lands inside the beats of a refill
    task automatic reset_in_burst();
        int idle;
        idle = 0;
        @(negedge clock);
        while (!fetching_o && !aborted) begin
            @(negedge clock);
            idle++;
            if (idle > WAIT_LIMIT) begin
                $display("timeout: refill never started before reset");
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            repeat (3) @(posedge clock);
            @(negedge clock);
            check_value("fetching_o", 64'(fetching_o), 64'd1);  // still in the burst
            @(posedge clock);
            reset <= 1'b0;
            @(negedge clock);
            check_value("instr_valid_o", 64'(instr_valid_o), 64'd0);
            check_value("fetching_o", 64'(fetching_o), 64'd0);
            repeat (10) @(posedge clock);
            reset <= 1'b1;
        end
    endtask

    initial begin
        reset         = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        instr_ready_i = 1'b0;
        lfsr          = 32'h9310;
        checks        = 0;
        errors        = 0;
        tests         = 0;
        failed_tests  = 0;
        aborted       = 1'b0;
        held_pc       = '0;
        $readmemh("rom.hex", model_rom);

        rows[0] = '{RESET_PC + 64'h38, 16'd10, 1'b1};      // inside held line
        rows[1] = '{RESET_PC + 64'h08, 16'd8, 1'b0};
        rows[2] = '{RESET_PC + 64'h24, 16'd6, 1'b1};       // inside again
        rows[3] = '{RESET_PC + 64'hE8, 16'd12, 1'b1};      // runs past rom end
        rows[4] = '{RESET_PC + 64'h11C, 16'd6, 1'b0};
        rows[5] = '{64'h0000_0000_8001_0040, 16'd8, 1'b1}; // far alias
        rows[6] = '{64'h0000_0000_7FFF_FFF0, 16'd8, 1'b1}; // below base, wraps
        rows[7] = '{RESET_PC + 64'h7C, 16'd5, 1'b0};

        repeat (10) @(posedge clock);
        reset <= 1'b1;

        errs_before = errors;
        collect_instrs("start from reset", RESET_PC, 12, 1'b0, 1'b1);
        report_test("start from reset");

        for (int i = 0; i < ROWS && !aborted; i++) begin
            errs_before = errors;
            hold_instr();
            if (!aborted) begin
                apply_redirect(rows[i].target);
                collect_instrs($sformatf("redirect %0d", i), rows[i].target,
                               int'(rows[i].count), rows[i].stall,
                               line_of(rows[i].target) != line_of(held_pc));
            end
            report_test($sformatf("redirect to %h", rows[i].target));
        end

        if (!aborted) begin
            errs_before = errors;
            hold_instr();
            if (!aborted) begin
                apply_redirect(RESET_PC + 64'hC0);
                reset_in_burst();
                collect_instrs("restart after reset", RESET_PC, 8, 1'b1, 1'b1);
            end
            report_test("reset in burst");
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/core_pkg.sv
logic/axi_pkg.sv
logic/axi_rd_master.sv
logic/axi_rom_slave.sv
logic/fetch_unit.sv
logic/fetch_top.sv
verif/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
    -f compile.f -o fetch_sim > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1 \
    || echo "Result: FAILED" >> sim.log
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0

//--- rom.hex
// one 64-bit word per line, word i sits at byte offset 8*i from the reset pc
// high half is the instruction at pc+4, low half the one at pc
6f00000113000000
6f00000313000002
6f00000513000004
6f00000713000006
6f00000913000008
6f00000b1300000a
6f00000d1300000c
6f00000f1300000e
6f00001113000010
6f00001313000012
6f00001513000014
6f00001713000016
6f00001913000018
6f00001b1300001a
6f00001d1300001c
6f00001f1300001e
6f00002113000020
6f00002313000022
6f00002513000024
6f00002713000026
6f00002913000028
6f00002b1300002a
6f00002d1300002c
6f00002f1300002e
6f00003113000030
6f00003313000032
6f00003513000034
6f00003713000036
6f00003913000038
6f00003b1300003a
6f00003d1300003c
6f00003f1300003e
